// ==== alu.sv ====
// combinational integer alu for the rv32i core
`default_nettype none

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // only low 5 bits shift

    always_comb begin
        case (op)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_slt:  result = rv_pkg::word_t'($signed(a) < $signed(b));
            rv_pkg::alu_sltu: result = rv_pkg::word_t'(a < b);
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = rv_pkg::word_t'($signed(a) >>> shamt);
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_and:  result = a & b;
            default:          result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
// rv32i core top, instruction word comes in on a plain port
// retire signals mirror each register write for the testbench
`default_nettype none

module cpu_core (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::word_t     inst,
    output logic              fetch_req,
    output rv_pkg::word_t     fetch_addr,
    output logic              retire_valid,
    output rv_pkg::word_t     retire_pc,
    output logic              retire_we,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::word_t     retire_wdata
);

    rv_pkg::word_t      pc;
    logic               exec_en;
    logic               jump_en;
    rv_pkg::word_t      jump_target;

    rv_pkg::reg_addr_t  rs1;
    rv_pkg::reg_addr_t  rs2;
    rv_pkg::reg_addr_t  rd;
    logic [2:0]         funct3;
    rv_pkg::word_t      imm;
    rv_pkg::inst_type_t inst_type;
    rv_pkg::alu_op_t    alu_op;
    rv_pkg::wb_sel_t    wb_sel;

    rv_pkg::word_t      rs1_data;
    rv_pkg::word_t      rs2_data;
    logic               rf_we;
    rv_pkg::word_t      rf_wdata;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .fetch_req   (fetch_req),
        .exec_en     (exec_en)
    );

    decoder u_decoder (
        .inst      (inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .funct3    (funct3),
        .imm       (imm),
        .inst_type (inst_type),
        .alu_op    (alu_op),
        .wb_sel    (wb_sel)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (rd),
        .wdata  (rf_wdata),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    execute_unit u_exec (
        .exec_en     (exec_en),
        .inst_type   (inst_type),
        .opcode      (inst[6:0]),  // raw opcode field
        .funct3      (funct3),
        .alu_op      (alu_op),
        .wb_sel      (wb_sel),
        .rd          (rd),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .pc          (pc),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .rf_we       (rf_we),
        .rf_wdata    (rf_wdata)
    );

    assign fetch_addr   = pc;
    assign retire_valid = exec_en;
    assign retire_pc    = pc;
    assign retire_we    = rf_we;
    assign retire_rd    = rd;
    assign retire_wdata = rf_wdata;

endmodule

`default_nettype wire

// ==== decoder.sv ====
// rv32i instruction decode, purely combinational
// yields register fields, format, immediate, alu op and write-back select
`default_nettype none

module decoder (
    input  rv_pkg::word_t      inst,
    output rv_pkg::reg_addr_t  rs1,
    output rv_pkg::reg_addr_t  rs2,
    output rv_pkg::reg_addr_t  rd,
    output logic [2:0]         funct3,
    output rv_pkg::word_t      imm,
    output rv_pkg::inst_type_t inst_type,
    output rv_pkg::alu_op_t    alu_op,
    output rv_pkg::wb_sel_t    wb_sel
);

    rv_pkg::opcode_t opcode;
    logic [6:0]      funct7;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    // format and write-back source from the opcode
    always_comb begin
        case (opcode)
            rv_pkg::OP_REG:    begin inst_type = rv_pkg::type_r; end
            rv_pkg::OP_IMM,
            rv_pkg::OP_JALR:   begin inst_type = rv_pkg::type_i; end
            rv_pkg::OP_BRANCH: begin inst_type = rv_pkg::type_b; end
            rv_pkg::OP_LUI,
            rv_pkg::OP_AUIPC:  begin inst_type = rv_pkg::type_u; end
            rv_pkg::OP_JAL:    begin inst_type = rv_pkg::type_j; end
            default:           begin inst_type = rv_pkg::type_n; end  // loads, stores, system
        endcase
    end

    always_comb begin
        case (opcode)
            rv_pkg::OP_REG, rv_pkg::OP_IMM,
            rv_pkg::OP_LUI, rv_pkg::OP_AUIPC: wb_sel = rv_pkg::wb_alu;
            rv_pkg::OP_JAL, rv_pkg::OP_JALR:  wb_sel = rv_pkg::wb_link;
            default:                          wb_sel = rv_pkg::wb_none;
        endcase
    end

    // sign-extended immediates
    always_comb begin
        case (inst_type)
            rv_pkg::type_i: imm = {{20{inst[31]}}, inst[31:20]};
            rv_pkg::type_b: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::type_u: imm = {inst[31:12], 12'b0};
            rv_pkg::type_j: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:        imm = '0;
        endcase
    end

    // add for address and upper-immediate math
    always_comb begin
        alu_op = rv_pkg::alu_add;
        if (opcode == rv_pkg::OP_REG || opcode == rv_pkg::OP_IMM) begin
            case (funct3)
                3'b000: begin
                    if (opcode == rv_pkg::OP_REG && funct7 == 7'b0100000) begin
                        alu_op = rv_pkg::alu_sub;  // no subi in rv32i
                    end
                end
                3'b001:  alu_op = rv_pkg::alu_sll;
                3'b010:  alu_op = rv_pkg::alu_slt;
                3'b011:  alu_op = rv_pkg::alu_sltu;
                3'b100:  alu_op = rv_pkg::alu_xor;
                3'b101:  alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                3'b110:  alu_op = rv_pkg::alu_or;
                3'b111:  alu_op = rv_pkg::alu_and;
                default: alu_op = rv_pkg::alu_add;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== execute_unit.sv ====
// execute stage: operand muxing, branch compare, jump target, write-back select
// all combinational around one alu
`default_nettype none

module execute_unit (
    input  logic               exec_en,
    input  rv_pkg::inst_type_t inst_type,
    input  rv_pkg::opcode_t    opcode,
    input  logic [2:0]         funct3,
    input  rv_pkg::alu_op_t    alu_op,
    input  rv_pkg::wb_sel_t    wb_sel,
    input  rv_pkg::reg_addr_t  rd,
    input  rv_pkg::word_t      rs1_data,
    input  rv_pkg::word_t      rs2_data,
    input  rv_pkg::word_t      imm,
    input  rv_pkg::word_t      pc,
    output logic               jump_en,
    output rv_pkg::word_t      jump_target,
    output logic               rf_we,
    output rv_pkg::word_t      rf_wdata
);

    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    rv_pkg::word_t link_addr;
    logic          branch_taken;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    always_comb begin
        case (inst_type)
            rv_pkg::type_r: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            rv_pkg::type_i: begin  // op-imm and jalr
                alu_a = rs1_data;
                alu_b = imm;
            end
            rv_pkg::type_b, rv_pkg::type_j: begin
                alu_a = pc;  // branch/jump target
                alu_b = imm;
            end
            rv_pkg::type_u: begin
                alu_a = (opcode == rv_pkg::OP_LUI) ? '0 : pc;
                alu_b = imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (rs1_data == rs2_data);
            3'b001:  branch_taken = (rs1_data != rs2_data);
            3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  branch_taken = (rs1_data < rs2_data);
            3'b111:  branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        if (inst_type == rv_pkg::type_b) begin
            jump_en = branch_taken;
        end else if (inst_type == rv_pkg::type_j) begin
            jump_en = 1'b1;
        end else if (opcode == rv_pkg::OP_JALR) begin
            jump_en     = 1'b1;
            jump_target = {alu_result[rv_pkg::XLEN-1:1], 1'b0};  // jalr clears bit 0
        end
    end

    assign link_addr = pc + rv_pkg::word_t'(4);

    assign rf_we    = exec_en && (wb_sel != rv_pkg::wb_none) && (rd != '0);
    assign rf_wdata = (wb_sel == rv_pkg::wb_link) ? link_addr : alu_result;

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
// pc register and the two-state fetch/execute sequencer
// one instruction retires every second cycle
`default_nettype none

module fetch_unit (
    input  logic          clk,
    input  logic          reset,
    input  logic          jump_en,
    input  rv_pkg::word_t jump_target,
    output rv_pkg::word_t pc,
    output logic          fetch_req,
    output logic          exec_en
);

    rv_pkg::core_state_t state;
    rv_pkg::word_t       next_pc;

    assign fetch_req = (state == rv_pkg::st_fetch);
    assign exec_en   = (state == rv_pkg::st_exec);

    // redirect from execute, else sequential
    assign next_pc = jump_en ? jump_target : pc + rv_pkg::word_t'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rv_pkg::st_fetch;
        end else begin
            case (state)
                rv_pkg::st_fetch: state <= rv_pkg::st_exec;
                rv_pkg::st_exec:  state <= rv_pkg::st_fetch;
                default:          state <= rv_pkg::st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= rv_pkg::RESET_PC;
        end else if (exec_en) begin
            pc <= next_pc;  // updates on the closing edge of execute
        end
    end

    never_both: assert property (
        @(posedge clk) disable iff (reset)
        !(fetch_req && exec_en)
    ) else $error("fetch_req and exec_en high together");

endmodule

`default_nettype wire

// ==== list.f ====
rv_pkg.sv
alu.sv
fetch_unit.sv
decoder.sv
reg_file.sv
execute_unit.sv
cpu_core.sv
+incdir+.
tb_cpu_core.sv

// ==== reg_file.sv ====
// general register file, two async read ports and one write port
// x0 reads as zero regardless of contents
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);

    rv_pkg::word_t regs [rv_pkg::REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rv_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;  // lands on the retire edge
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // execute unit must filter writes to x0
    no_x0_write: assert property (
        @(posedge clk) disable iff (reset)
        we |-> waddr != '0
    ) else $error("register write targets x0");

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
// shared widths, opcodes and enums for the rv32i core
// every core file refers to these by scoped name
`default_nettype none

package rv_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0] word_t;                    // data, pc and instruction words
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;   // register index
    typedef logic [6:0] opcode_t;

    localparam word_t RESET_PC = 32'h8000_0000;         // first fetch address

    // opcodes handled by the core, anything else retires as a no-op
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // instruction format, picks immediate layout and alu operands
    typedef enum logic [2:0] {
        type_r,
        type_i,
        type_b,
        type_u,
        type_j,
        type_n  // unsupported or no operands
    } inst_type_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // write-back source
    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_link
    } wb_sel_t;

    typedef enum logic {
        st_fetch,
        st_exec
    } core_state_t;

endpackage

`default_nettype wire

// ==== tb_ref_model.svh ====
// testbench helpers: lfsr stimulus, rv32i encoders and the reference register model
// included inside the testbench top, which declares nothing these depend on
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [31:0] lfsr_state = 32'hc543_bd26;
logic [31:0] model_regs [32];   // x0 is never written, stays zero
logic [31:0] model_pc;

// galois lfsr, stepped once for every bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                      input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
endfunction

// integer ops by funct3, alt selects sub or arithmetic shift
function automatic logic [31:0] arith_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];  // sign bit fills from the left
            end
            return a >> b[4:0];
        end
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// retire one word on the model: expected write and new model pc
task automatic ref_execute(input logic [31:0] w, output logic we, output logic [4:0] rd,
                           output logic [31:0] wdata);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] next;
    logic        writes;
    logic        taken;
    a = model_regs[w[19:15]];
    b = model_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    next = model_pc + 4;
    writes = 1'b1;
    wdata = '0;
    case (w[6:0])
        rv_pkg::OP_REG:   wdata = arith_ref(w[14:12], w[30], a, b);
        rv_pkg::OP_IMM:   wdata = arith_ref(w[14:12], w[30] && w[14:12] == 3'd5, a, imm_i);
        rv_pkg::OP_LUI:   wdata = {w[31:12], 12'b0};
        rv_pkg::OP_AUIPC: wdata = model_pc + {w[31:12], 12'b0};
        rv_pkg::OP_JAL: begin
            wdata = model_pc + 4;
            next = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        rv_pkg::OP_JALR: begin
            wdata = model_pc + 4;
            next = (a + imm_i) & ~32'h1;
        end
        rv_pkg::OP_BRANCH: begin
            writes = 1'b0;
            case (w[14:12])
                3'd0:    taken = a == b;
                3'd1:    taken = a != b;
                3'd4:    taken = $signed(a) < $signed(b);
                3'd5:    taken = $signed(a) >= $signed(b);
                3'd6:    taken = a < b;
                3'd7:    taken = a >= b;
                default: taken = 1'b0;
            endcase
            if (taken) next = model_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        default: writes = 1'b0;  // loads, stores, system and the rest
    endcase
    rd = w[11:7];
    we = writes && rd != 5'd0;
    if (we) model_regs[rd] = wdata;
    model_pc = next;
endtask

`endif

// ==== tb_cpu_core.sv ====
// testbench for cpu_core: feeds directed then random rv32i words on each fetch
// checks retire and fetch signals against the reference model with assertions
`default_nettype none

module tb_cpu_core;

    localparam int N_RANDOM = 200;

    logic              clk;
    logic              reset;
    rv_pkg::word_t     inst;
    logic              fetch_req;
    rv_pkg::word_t     fetch_addr;
    logic              retire_valid;
    rv_pkg::word_t     retire_pc;
    logic              retire_we;
    rv_pkg::reg_addr_t retire_rd;
    rv_pkg::word_t     retire_wdata;

    logic [31:0] program_q [$];
    logic        exp_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_wdata;
    logic [31:0] exp_pc;
    logic [31:0] exp_fetch_addr;
    int          mismatch_count = 0;
    int          other_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    `include "tb_ref_model.svh"

    cpu_core dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: core stopped retiring after %0d cycles", cycle_count);
            $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
            $display("Test failures found");
            $finish;
        end
    end

    // state is only defined once the first reset edge has passed
    reset_quiet: assert property (@(posedge clk) reset |=> !retire_valid && !retire_we)
        else begin
            other_count++;
            $display("retire signals active during reset");
        end
    fetch_then_retire: assert property (@(posedge clk) disable iff (reset)
        fetch_req |=> retire_valid && !fetch_req)
        else begin
            other_count++;
            $display("fetch request not followed by a retire");
        end
    retire_then_fetch: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> fetch_req && !retire_valid)
        else begin
            other_count++;
            $display("retire not followed by a fetch request");
        end
    fetch_addr_ok: assert property (@(posedge clk) disable iff (reset)
        fetch_req |-> fetch_addr == exp_fetch_addr)
        else begin
            mismatch_count++;
            $display("mismatch at %0t: fetch_addr %h, expected %h", $time, fetch_addr,
                     exp_fetch_addr);
        end
    retire_pc_ok: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> retire_pc == exp_pc)
        else begin
            mismatch_count++;
            $display("mismatch at %0t: retire_pc %h, expected %h", $time, retire_pc, exp_pc);
        end
    write_ok: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> retire_we == exp_we &&
                         (!exp_we || (retire_rd == exp_rd && retire_wdata == exp_wdata)))
        else begin
            mismatch_count++;
            $display("mismatch at %0t: write we=%b x%0d=%h, expected we=%b x%0d=%h", $time,
                     retire_we, retire_rd, retire_wdata, exp_we, exp_rd, exp_wdata);
        end

    // random register or immediate arithmetic
    function automatic logic [31:0] random_arith();
        logic        is_reg;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm;
        is_reg = rand_bits(1);
        f3 = rand_bits(3);
        alt = rand_bits(1) && (f3 == 3'd0 || f3 == 3'd5);
        rd = rand_bits(5);
        rs1 = rand_bits(5);
        imm = rand_bits(12);
        if (is_reg) return enc_r({1'b0, alt, 5'b0}, imm[4:0], rs1, f3, rd);
        if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0]};
        return enc_i(rv_pkg::OP_IMM, rd, f3, rs1, imm);
    endfunction

    task automatic build_directed();
        program_q = {enc_i(rv_pkg::OP_IMM, 1, 0, 0, 5), enc_i(rv_pkg::OP_IMM, 2, 0, 0, -3),
                     {20'h80000, 5'd3, rv_pkg::OP_LUI}, enc_i(rv_pkg::OP_IMM, 0, 0, 1, 7),
                     enc_r(0, 1, 0, 0, 4), {20'h12345, 5'd5, rv_pkg::OP_AUIPC},
                     {20'habcde, 5'd6, rv_pkg::OP_LUI}};
        // each condition taken then not taken
        program_q.push_back(enc_b(0, 1, 1, 16));
        program_q.push_back(enc_b(0, 1, 2, 8));
        program_q.push_back(enc_b(1, 1, 2, -8));
        program_q.push_back(enc_b(1, 1, 1, 12));
        program_q.push_back(enc_b(4, 2, 1, 20));
        program_q.push_back(enc_b(4, 1, 2, 20));
        program_q.push_back(enc_b(5, 1, 2, -4));
        program_q.push_back(enc_b(5, 2, 1, -4));
        program_q.push_back(enc_b(6, 1, 2, 64));
        program_q.push_back(enc_b(6, 2, 1, 64));
        program_q.push_back(enc_b(7, 2, 1, -64));
        program_q.push_back(enc_b(7, 1, 2, -64));
        program_q.push_back(enc_j(7, 2048));
        program_q.push_back(enc_j(0, -12));
        program_q.push_back({20'h80001, 5'd8, rv_pkg::OP_LUI});
        program_q.push_back(enc_i(rv_pkg::OP_IMM, 8, 0, 8, 1));
        program_q.push_back(enc_i(rv_pkg::OP_JALR, 9, 0, 8, 6));  // odd target
        program_q.push_back(enc_i(7'b0000011, 10, 2, 1, 0));      // load
        program_q.push_back(32'h0020_a023);                       // store
        program_q.push_back(32'h0000_0073);                       // ecall
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        inst = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        model_pc = rv_pkg::RESET_PC;
        exp_fetch_addr = rv_pkg::RESET_PC;
        exp_pc = rv_pkg::RESET_PC;
        exp_we = 1'b0;
        exp_rd = '0;
        exp_wdata = '0;
        build_directed();
        for (int i = 0; i < N_RANDOM; i++) program_q.push_back(random_arith());
        cycle_limit = 2 * program_q.size() + 50;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        foreach (program_q[i]) begin
            @(posedge clk);
            #1;
            while (!retire_valid) begin  // wait for the execute cycle
                @(posedge clk);
                #1;
            end
            inst = program_q[i];
            exp_pc = model_pc;
            ref_execute(program_q[i], exp_we, exp_rd, exp_wdata);
            exp_fetch_addr = model_pc;
        end
        repeat (2) @(posedge clk);  // last retire and the fetch after it
        #1;
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
